//--- hw/mem_request_pkg.sv
/*
  Shared definitions for the memory request generator
  Widths, APB register map, source ids and the packed bus structs
*/

package mem_request_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int addr_width     = 32;
  localparam int count_width    = 16;
  localparam int line_bytes     = 64;
  localparam int apb_addr_width = 8;

  // APB register offsets
  localparam logic [apb_addr_width-1:0] reg_ctrl         = 8'h00;
  localparam logic [apb_addr_width-1:0] reg_status       = 8'h04;
  localparam logic [apb_addr_width-1:0] reg_vertex_base  = 8'h08;
  localparam logic [apb_addr_width-1:0] reg_vertex_count = 8'h0C;
  localparam logic [apb_addr_width-1:0] reg_edge_base    = 8'h10;
  localparam logic [apb_addr_width-1:0] reg_edge_count   = 8'h14;

  // Request source ids
  localparam logic array_vertex = 1'b0;
  localparam logic array_edge   = 1'b1;

  // --------------------------------------------------
  // Packed structs
  // --------------------------------------------------
  // One array, base byte address plus element count
  typedef struct packed {
    logic [addr_width-1:0]  base_addr;
    logic [count_width-1:0] count;
  } array_desc_t;

  // One cache-line read request
  typedef struct packed {
    logic [addr_width-1:0]  addr;
    logic                   array_id;
    logic [count_width-1:0] index;
  } mem_req_t;

  // STATUS bits 1:0, busy on top
  typedef struct packed {
    logic busy;
    logic done;
  } status_t;

  // APB requester side
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [31:0]               pwdata;
  } apb_req_t;

  // APB completer side
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_resp_t;

endpackage : mem_request_pkg

//--- hw/apb_control_regs.sv
/*
  APB register file with CTRL, STATUS and the two array descriptors
  One-cycle start pulse, busy/done tracking and slave error decode
*/

`timescale 1ns/1ps

module apb_control_regs (
  input  logic                          ap_clk,
  input  logic                          control_areset,
  input  mem_request_pkg::apb_req_t     apb_in,
  output mem_request_pkg::apb_resp_t    apb_out,
  output logic                          start,
  output mem_request_pkg::array_desc_t  vertex_desc,
  output mem_request_pkg::array_desc_t  edge_desc,
  input  logic                          vertex_done,
  input  logic                          edge_done,
  input  logic                          drained
);

  import mem_request_pkg::*;

  // --------------------------------------------------
  // Access decode
  // --------------------------------------------------
  status_t status_q;
  logic    access;
  logic    mapped;
  logic    locked;
  logic    slv_err;
  logic    wr_ok;

  // Zero wait states, so setup plus enable is the whole access
  assign access = apb_in.psel & apb_in.penable;

  always_comb begin
    mapped = 1'b1;
    locked = 1'b1;
    case (apb_in.paddr)
      reg_ctrl, reg_vertex_base, reg_vertex_count,
      reg_edge_base, reg_edge_count: locked = 1'b1;
      reg_status: locked = 1'b0;
      default: begin
        mapped = 1'b0;
        locked = 1'b0;
      end
    endcase
  end

  // Unmapped offset, or a write that would disturb a running walk
  assign slv_err = access & (~mapped | (apb_in.pwrite & locked & status_q.busy));
  assign wr_ok   = access & apb_in.pwrite & ~slv_err;

  // --------------------------------------------------
  // Descriptor registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      vertex_desc <= '0;
      edge_desc   <= '0;
    end else if (wr_ok) begin
      case (apb_in.paddr)
        reg_vertex_base:  vertex_desc.base_addr <= apb_in.pwdata;
        reg_vertex_count: vertex_desc.count     <= apb_in.pwdata[count_width-1:0];
        reg_edge_base:    edge_desc.base_addr   <= apb_in.pwdata;
        reg_edge_count:   edge_desc.count       <= apb_in.pwdata[count_width-1:0];
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // Start pulse and run status
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      start    <= 1'b0;
      status_q <= '0;
    end else begin
      start <= 1'b0;
      if (wr_ok && apb_in.paddr == reg_ctrl && apb_in.pwdata[0]) begin
        // Only reachable while idle, locked writes are rejected above
        start         <= 1'b1;
        status_q.busy <= 1'b1;
        status_q.done <= 1'b0;
      end else if (status_q.busy && !start && vertex_done && edge_done && drained) begin
        // Generator done flags are stale during the start cycle itself
        status_q.busy <= 1'b0;
        status_q.done <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    apb_out.pready  = 1'b1;
    apb_out.pslverr = slv_err;
    case (apb_in.paddr)
      reg_status:       apb_out.prdata = {30'd0, status_q};
      reg_vertex_base:  apb_out.prdata = vertex_desc.base_addr;
      reg_vertex_count: apb_out.prdata = {{(32-count_width){1'b0}}, vertex_desc.count};
      reg_edge_base:    apb_out.prdata = edge_desc.base_addr;
      reg_edge_count:   apb_out.prdata = {{(32-count_width){1'b0}}, edge_desc.count};
      // CTRL is write-only, reads as zero
      default:          apb_out.prdata = 32'd0;
    endcase
  end

endmodule : apb_control_regs

//--- hw/array_request_gen.sv
/*
  Array walker issuing one line-read request per element
  Valid/ready output, done flag held until the next start
*/

`timescale 1ns/1ps

module array_request_gen #(
  parameter logic array_id = mem_request_pkg::array_vertex
) (
  input  logic                          ap_clk,
  input  logic                          control_areset,
  input  logic                          start,
  input  mem_request_pkg::array_desc_t  desc,
  output mem_request_pkg::mem_req_t     req,
  output logic                          req_valid,
  input  logic                          req_ready,
  output logic                          gen_done
);

  import mem_request_pkg::*;

  localparam int line_shift = $clog2(line_bytes);

  // Latched descriptor for the current walk
  logic [addr_width-1:0]  base_q;
  logic [count_width-1:0] count_q;
  logic [count_width-1:0] index_q;
  logic                   xfer;
  logic                   last;

  assign xfer = req_valid & req_ready;
  assign last = (index_q == count_q - count_width'(1));

  always_ff @(posedge ap_clk) begin
    if (start) begin
      base_q  <= desc.base_addr;
      count_q <= desc.count;
    end
  end

  // --------------------------------------------------
  // Walk control
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      index_q   <= '0;
      req_valid <= 1'b0;
      gen_done  <= 1'b0;
    end else if (start) begin
      index_q   <= '0;
      // Empty array finishes right away
      req_valid <= (desc.count != '0);
      gen_done  <= (desc.count == '0);
    end else if (xfer) begin
      if (last) begin
        req_valid <= 1'b0;
        gen_done  <= 1'b1;
      end else begin
        index_q <= index_q + count_width'(1);
      end
    end
  end

  // Request fields only move on a transfer, so they stay stable while stalled
  assign req.addr     = base_q + (addr_width'(index_q) << line_shift);
  assign req.array_id = array_id;
  assign req.index    = index_q;

endmodule : array_request_gen

//--- hw/request_arbiter.sv
/*
  Two-input round-robin request arbiter
  Registered output stage that holds under back-pressure
*/

`timescale 1ns/1ps

module request_arbiter (
  input  logic                       ap_clk,
  input  logic                       control_areset,
  input  mem_request_pkg::mem_req_t  vertex_req,
  input  logic                       vertex_valid,
  output logic                       vertex_ready,
  input  mem_request_pkg::mem_req_t  edge_req,
  input  logic                       edge_valid,
  output logic                       edge_ready,
  output mem_request_pkg::mem_req_t  mem_req,
  output logic                       mem_req_valid,
  input  logic                       mem_req_ready,
  output logic                       drained
);

  import mem_request_pkg::*;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------
  // Priority bit, low favours vertex
  logic prio_edge;
  logic load_ok;
  logic grant_vertex;
  logic grant_edge;
  logic accept;

  // Stage free now or emptied this cycle
  assign load_ok = ~mem_req_valid | mem_req_ready;

  // Lone requester always wins, tie broken by the priority bit
  assign grant_vertex = vertex_valid & (~edge_valid | ~prio_edge);
  assign grant_edge   = edge_valid & (~vertex_valid | prio_edge);

  assign vertex_ready = load_ok & grant_vertex;
  assign edge_ready   = load_ok & grant_edge;
  assign accept       = vertex_ready | edge_ready;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      prio_edge <= 1'b0;
    end else if (accept) begin
      // Hand priority to the source that just lost or sat out
      prio_edge <= grant_vertex;
    end
  end

  // --------------------------------------------------
  // Output stage
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      mem_req_valid <= 1'b0;
    end else if (accept) begin
      mem_req_valid <= 1'b1;
    end else if (mem_req_ready) begin
      mem_req_valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) begin
      mem_req <= grant_vertex ? vertex_req : edge_req;
    end
  end

  assign drained = ~mem_req_valid;

endmodule : request_arbiter

//--- hw/mem_request_top.sv
/*
  Memory request generator top
  APB control, vertex and edge walkers, round-robin merge
*/

`timescale 1ns/1ps

module mem_request_top (
  input  logic                        ap_clk,
  input  logic                        control_areset,
  input  mem_request_pkg::apb_req_t   apb_in,
  output mem_request_pkg::apb_resp_t  apb_out,
  output mem_request_pkg::mem_req_t   mem_req,
  output logic                        mem_req_valid,
  input  logic                        mem_req_ready
);

  import mem_request_pkg::*;

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------
  logic        start;
  array_desc_t vertex_desc;
  array_desc_t edge_desc;
  mem_req_t    vertex_req;
  logic        vertex_valid;
  logic        vertex_ready;
  logic        vertex_done;
  mem_req_t    edge_req;
  logic        edge_valid;
  logic        edge_ready;
  logic        edge_done;
  logic        drained;

  // Host registers and run control
  apb_control_regs apb_control_regs_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .apb_in         (apb_in),
    .apb_out        (apb_out),
    .start          (start),
    .vertex_desc    (vertex_desc),
    .edge_desc      (edge_desc),
    .vertex_done    (vertex_done),
    .edge_done      (edge_done),
    .drained        (drained)
  );

  // Vertex array walker
  array_request_gen #(
    .array_id (array_vertex)
  ) vertex_gen_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .start          (start),
    .desc           (vertex_desc),
    .req            (vertex_req),
    .req_valid      (vertex_valid),
    .req_ready      (vertex_ready),
    .gen_done       (vertex_done)
  );

  // Edge array walker
  array_request_gen #(
    .array_id (array_edge)
  ) edge_gen_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .start          (start),
    .desc           (edge_desc),
    .req            (edge_req),
    .req_valid      (edge_valid),
    .req_ready      (edge_ready),
    .gen_done       (edge_done)
  );

  // Merge onto the single memory port
  request_arbiter request_arbiter_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .vertex_req     (vertex_req),
    .vertex_valid   (vertex_valid),
    .vertex_ready   (vertex_ready),
    .edge_req       (edge_req),
    .edge_valid     (edge_valid),
    .edge_ready     (edge_ready),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .drained        (drained)
  );

endmodule : mem_request_top

//--- verification/mem_request_checks.svh
/*
  Compare tasks for requests, run status and APB responses
  Pass and fail counters shared across the testbench
*/

`ifndef MEM_REQUEST_CHECKS_SVH
`define MEM_REQUEST_CHECKS_SVH

// Running totals for the closing summary
int checks_passed = 0;
int checks_failed = 0;

// One line-read request, all fields at once
task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
  if (got === exp) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("CHECK FAILED at %0t: %s got addr %h id %0d index %0d", $time, what,
             got.addr, got.array_id, got.index);
    $display("  expected addr %h id %0d index %0d", exp.addr, exp.array_id, exp.index);
  end
endtask

// STATUS busy and done
task automatic check_status(input status_t got, input status_t exp, input string what);
  if (got === exp) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("CHECK FAILED at %0t: %s got busy %b done %b, expected busy %b done %b",
             $time, what, got.busy, got.done, exp.busy, exp.done);
  end
endtask

// Full APB completer response
task automatic check_apb_resp(input apb_resp_t got, input apb_resp_t exp, input string what);
  if (got === exp) begin
    checks_passed++;
  end else begin
    checks_failed++;
    $display("CHECK FAILED at %0t: %s got prdata %h pslverr %b, expected prdata %h pslverr %b",
             $time, what, got.prdata, got.pslverr, exp.prdata, exp.pslverr);
  end
endtask

`endif

//--- verification/mem_request_tb.sv
/*
  Testbench for the memory request generator
  Clock, reset, APB driver, pattern reader, request scoreboard, watchdog
*/

`timescale 1ns/1ps

module mem_request_tb;

  import mem_request_pkg::*;

  `include "mem_request_checks.svh"

  // --------------------------------------------------
  // DUT and clock
  // --------------------------------------------------
  logic      ap_clk = 1'b0;
  logic      control_areset;
  apb_req_t  apb_in;
  apb_resp_t apb_out;
  mem_req_t  mem_req;
  logic      mem_req_valid;
  logic      mem_req_ready;

  // Pattern table, one entry per test
  array_desc_t v_list[$];
  array_desc_t e_list[$];
  logic        stall_list[$];

  // Scoreboard queues and model state
  mem_req_t exp_q[$];
  mem_req_t got_q[$];
  logic     model_prio_edge;
  logic     stall_on;
  integer   seed;
  logic [31:0] rnd;

  // File reading
  integer        fd;
  integer        fields;
  reg [8*128-1:0] line_buf;
  logic [31:0]   f_vb, f_vc, f_eb, f_ec, f_st;
  longint        limit_cycles;
  array_desc_t   vd_rd, ed_rd;

  always #5 ap_clk = ~ap_clk;

  mem_request_top mem_request_top_i (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .apb_in         (apb_in),
    .apb_out        (apb_out),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready)
  );

  // Memory side sink
  // Sampled before this edge's updates, ready driven for the next cycle
  always @(posedge ap_clk) begin
    if (mem_req_valid && mem_req_ready) begin
      got_q.push_back(mem_req);
    end
    rnd = $random(seed);
    mem_req_ready <= stall_on ? rnd[0] : 1'b1;
  end

  // --------------------------------------------------
  // APB driver
  // --------------------------------------------------
  // Setup then access, response taken at the edge ending the access
  task automatic bus_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output apb_resp_t resp);
    apb_req_t req;
    req = '0;
    req.psel   = 1'b1;
    req.pwrite = write;
    req.paddr  = addr;
    req.pwdata = wdata;
    apb_in <= req;
    @(posedge ap_clk);
    req.penable = 1'b1;
    apb_in <= req;
    @(posedge ap_clk);
    resp = apb_out;
    apb_in <= '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    apb_resp_t got;
    apb_resp_t exp;
    bus_access(1'b1, addr, data, got);
    // Read data carries no meaning on a write
    exp.prdata  = got.prdata;
    exp.pready  = 1'b1;
    exp.pslverr = exp_err;
    check_apb_resp(got, exp, $sformatf("write to offset %h", addr));
  endtask

  // Read with unknown data, only the error flag is checked
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    apb_resp_t got;
    apb_resp_t exp;
    bus_access(1'b0, addr, 32'd0, got);
    exp.prdata  = got.prdata;
    exp.pready  = 1'b1;
    exp.pslverr = 1'b0;
    check_apb_resp(got, exp, $sformatf("read of offset %h", addr));
    data = got.prdata;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
    apb_resp_t got;
    apb_resp_t exp;
    bus_access(1'b0, addr, 32'd0, got);
    exp.prdata  = exp_data;
    exp.pready  = 1'b1;
    exp.pslverr = exp_err;
    check_apb_resp(got, exp, $sformatf("read of offset %h", addr));
  endtask

  // --------------------------------------------------
  // Expected request order
  // --------------------------------------------------
  // Round robin, lone source wins, priority flips to the other source
  task automatic build_expected(input array_desc_t vd, input array_desc_t ed);
    int       vi;
    int       ei;
    logic     take_edge;
    mem_req_t r;
    vi = 0;
    ei = 0;
    exp_q.delete();
    while (vi < vd.count || ei < ed.count) begin
      if (vi < vd.count && ei < ed.count) begin
        take_edge = model_prio_edge;
      end else begin
        take_edge = (ei < ed.count);
      end
      if (take_edge) begin
        r.addr     = ed.base_addr + ei * line_bytes;
        r.array_id = array_edge;
        r.index    = ei;
        ei++;
      end else begin
        r.addr     = vd.base_addr + vi * line_bytes;
        r.array_id = array_vertex;
        r.index    = vi;
        vi++;
      end
      model_prio_edge = ~take_edge;
      exp_q.push_back(r);
    end
  endtask

  // --------------------------------------------------
  // One pattern line
  // --------------------------------------------------
  task automatic run_test(input int t);
    array_desc_t vd;
    array_desc_t ed;
    status_t     st;
    status_t     exp_st;
    logic [31:0] data;
    int          fails_before;
    int          total;
    int          polls;
    vd = v_list[t];
    ed = e_list[t];
    fails_before = checks_failed;
    stall_on = stall_list[t];
    write_reg(reg_vertex_base, vd.base_addr, 1'b0);
    write_reg(reg_vertex_count, {16'd0, vd.count}, 1'b0);
    write_reg(reg_edge_base, ed.base_addr, 1'b0);
    write_reg(reg_edge_count, {16'd0, ed.count}, 1'b0);
    read_check(reg_vertex_base, vd.base_addr, 1'b0);
    read_check(reg_vertex_count, {16'd0, vd.count}, 1'b0);
    read_check(reg_edge_base, ed.base_addr, 1'b0);
    read_check(reg_edge_count, {16'd0, ed.count}, 1'b0);
    build_expected(vd, ed);
    total = exp_q.size();
    got_q.delete();
    write_reg(reg_ctrl, 32'd1, 1'b0);
    // Short runs could finish before the read lands
    if (total >= 2) begin
      read_reg(reg_status, data);
      st = data[1:0];
      exp_st.busy = 1'b1;
      exp_st.done = 1'b0;
      check_status(st, exp_st, "status during run");
    end
    // Locked writes, run keeps going on the old descriptor
    if (total >= 8) begin
      write_reg(reg_vertex_base, ~vd.base_addr, 1'b1);
      write_reg(reg_ctrl, 32'd1, 1'b1);
    end
    while (got_q.size() < total) begin
      @(posedge ap_clk);
    end
    st = '0;
    polls = 0;
    while (!st.done && polls < 50) begin
      read_reg(reg_status, data);
      st = data[1:0];
      polls++;
    end
    exp_st.busy = 1'b0;
    exp_st.done = 1'b1;
    check_status(st, exp_st, "status after last request");
    if (got_q.size() != total) begin
      checks_failed++;
      $display("Test %0d expected %0d requests but saw %0d", t, total, got_q.size());
    end
    for (int i = 0; i < total && i < got_q.size(); i++) begin
      check_req(got_q[i], exp_q[i], $sformatf("test %0d request %0d", t, i));
    end
    read_check(reg_vertex_base, vd.base_addr, 1'b0);
    $display("Test %0d: %0d requests, stall %0d, %s", t, total, stall_list[t],
             (checks_failed == fails_before) ? "ok" : "mismatches");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    control_areset = 1'b1;
    apb_in = '0;
    mem_req_ready = 1'b1;
    stall_on = 1'b0;
    seed = 52628;
    model_prio_edge = 1'b0;
    limit_cycles = 0;
    fd = $fopen("verification/mem_request_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      $display("Result: FAILED");
      $finish;
    end else begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
        fields = $sscanf(line_buf, "%h %h %h %h %h", f_vb, f_vc, f_eb, f_ec, f_st);
        // Comment and blank lines give fewer fields
        if (fields == 5) begin
          vd_rd.base_addr = f_vb;
          vd_rd.count     = f_vc[15:0];
          ed_rd.base_addr = f_eb;
          ed_rd.count     = f_ec[15:0];
          v_list.push_back(vd_rd);
          e_list.push_back(ed_rd);
          stall_list.push_back(f_st[0]);
          limit_cycles += (f_vc[15:0] + f_ec[15:0]) * 4 + 200;
        end
        line_buf = '0;
      end
      $fclose(fd);
      fork
        begin
          #(limit_cycles * 10);
          $display("Run timed out with requests still missing");
          $display("Result: FAILED");
          $finish;
        end
      join_none
      repeat (4) @(posedge ap_clk);
      control_areset <= 1'b0;
      @(posedge ap_clk);
      // Unmapped offsets and write-only CTRL
      write_reg(8'h18, 32'hdead_beef, 1'b1);
      read_check(8'h20, 32'd0, 1'b1);
      read_check(reg_ctrl, 32'd0, 1'b0);
      for (int t = 0; t < v_list.size(); t++) begin
        run_test(t);
      end
      $display("Checks passed %0d, failed %0d, tests %0d", checks_passed, checks_failed,
               v_list.size());
      if (checks_failed == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule : mem_request_tb

//--- verification/mem_request_patterns.txt
# Columns in hex: vertex_base vertex_count edge_base edge_count stall
# stall 1 drives mem_req_ready from the seeded random stream
00001000 8 00080000 8 0
00002000 c 00090040 5 1
00003000 0 000a0000 9 1
00004000 a 000b0000 0 0
10000000 10 20000000 3 1
00000000 1 00000040 1 0
00005000 0 00006000 0 0
fffff000 6 7fffffc0 b 1
00010000 14 00020000 14 1

//--- mem_request_top.f
hw/mem_request_pkg.sv
hw/apb_control_regs.sv
hw/array_request_gen.sv
hw/request_arbiter.sv
hw/mem_request_top.sv
+incdir+verification
verification/mem_request_tb.sv
